//--- hdl/div_pkg.sv
// divide unit shared definitions
// widths, lane count, opcodes, lane states and the request/response messages
`default_nettype none

package div_pkg;

  // --------------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------------

  // operand and result width
  localparam int data_width = 32;

  // number of divider lanes, must be a power of two
  localparam int num_lanes = 4;

  // lane pointer width, log2 of num_lanes
  localparam int lane_idx_width = $clog2(num_lanes);

  // one shift-subtract step per result bit
  localparam int lane_iters = data_width;

  // --------------------------------------------------------------------------
  // opcodes and states
  // --------------------------------------------------------------------------

  // unsigned or signed division
  typedef enum logic {
    op_divu = 1'b0,
    op_div  = 1'b1
  } div_op_e;

  // lane control FSM
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_fix  = 2'd2,
    st_done = 2'd3
  } lane_state_e;

  // --------------------------------------------------------------------------
  // messages
  // --------------------------------------------------------------------------

  // request, 65 bits
  typedef struct packed {
    div_op_e                 op;
    logic [data_width-1:0]   a;
    logic [data_width-1:0]   b;
  } div_req_t;

  // response, 64 bits, remainder in the upper half
  typedef struct packed {
    logic [data_width-1:0]   remainder;
    logic [data_width-1:0]   quotient;
  } div_resp_t;

endpackage

`default_nettype wire

//--- hdl/div_dispatch.sv
// divide request dispatcher
// sends each accepted request to the lane named by a round-robin pointer
`default_nettype none
`timescale 1ns/1ns

module div_dispatch (
  input  logic                                clk,
  input  logic                                reset,

  // upstream request
  input  logic                                req_val,
  input  div_pkg::div_req_t                   req_msg,
  output logic                                req_rdy,

  // per-lane request
  output logic [div_pkg::num_lanes-1:0]       lane_req_val,
  output div_pkg::div_req_t                   lane_req_msg,
  input  logic [div_pkg::num_lanes-1:0]       lane_req_rdy
);

  // --------------------------------------------------------------------------
  // round-robin pointer
  // --------------------------------------------------------------------------

  // lane whose turn it is
  logic [div_pkg::lane_idx_width-1:0] ptr;

  // one transfer into the lane at ptr
  logic issue;

  assign issue = req_val && req_rdy;

  // advance only on an accepted request
  // wraps naturally since the lane count is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (issue) begin
      ptr <= ptr + div_pkg::lane_idx_width'(1);
    end
  end

  // --------------------------------------------------------------------------
  // routing
  // --------------------------------------------------------------------------

  // payload goes to every lane, only the pointed lane sees val
  assign lane_req_msg = req_msg;

  always_comb begin
    lane_req_val = '0;
    // raise the pointed lane's bit whenever a request is offered
    lane_req_val[ptr] = req_val;
  end

  // stall on a busy lane instead of skipping it
  // keeps issue order equal to the collector's drain order
  assign req_rdy = lane_req_rdy[ptr];

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // at most one lane offered a request, and only the one at the pointer
  a_val_at_ptr_only: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(lane_req_val) && ((lane_req_val == '0) || lane_req_val[ptr])
  );

endmodule

`default_nettype wire

//--- hdl/div_lane.sv
// iterative restoring divider lane
// 32 shift-subtract steps, then a sign fix; holds one request at a time
`default_nettype none
`timescale 1ns/1ns

module div_lane (
  input  logic                clk,
  input  logic                reset,

  // request side
  input  logic                req_val,
  input  div_pkg::div_req_t   req_msg,
  output logic                req_rdy,

  // response side
  output logic                resp_val,
  output div_pkg::div_resp_t  resp_msg,
  input  logic                resp_rdy
);

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------

  div_pkg::lane_state_e state;

  // one extra bit so an overrun would be visible
  logic [$clog2(div_pkg::lane_iters):0] iter_cnt;

  logic accept;
  logic take;

  // one item per lane, so only idle takes a request
  assign req_rdy  = (state == div_pkg::st_idle);
  assign resp_val = (state == div_pkg::st_done);

  assign accept = req_val && req_rdy;
  assign take   = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= div_pkg::st_idle;
      iter_cnt <= '0;
    end else begin
      case (state)
        div_pkg::st_idle: begin
          if (accept) begin
            state    <= div_pkg::st_calc;
            iter_cnt <= '0;
          end
        end
        div_pkg::st_calc: begin
          // last step at count 31
          if (iter_cnt == div_pkg::lane_iters - 1) begin
            state <= div_pkg::st_fix;
          end else begin
            iter_cnt <= iter_cnt + 1'b1;
          end
        end
        div_pkg::st_fix: begin
          state <= div_pkg::st_done;
        end
        div_pkg::st_done: begin
          // hold the result until the collector takes it
          if (take) begin
            state <= div_pkg::st_idle;
          end
        end
        default: begin
          state <= div_pkg::st_idle;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // operand prep
  // --------------------------------------------------------------------------

  // signs only count for the signed op
  logic in_a_neg;
  logic in_b_neg;
  logic [div_pkg::data_width-1:0] in_a_mag;
  logic [div_pkg::data_width-1:0] in_b_mag;

  assign in_a_neg = (req_msg.op == div_pkg::op_div) && req_msg.a[div_pkg::data_width-1];
  assign in_b_neg = (req_msg.op == div_pkg::op_div) && req_msg.b[div_pkg::data_width-1];

  // most negative value maps to itself, correct as an unsigned magnitude
  assign in_a_mag = in_a_neg ? -req_msg.a : req_msg.a;
  assign in_b_mag = in_b_neg ? -req_msg.b : req_msg.b;

  // --------------------------------------------------------------------------
  // restoring datapath
  // --------------------------------------------------------------------------

  // remainder in the upper half, quotient shifts in at bit 0
  // top bit is the trial sign
  logic [2*div_pkg::data_width:0] rq_q;
  // divisor aligned with the remainder half
  logic [2*div_pkg::data_width:0] dvs_q;

  logic a_neg_q;
  logic b_neg_q;
  logic b_zero_q;

  logic [2*div_pkg::data_width:0] rq_shift;
  logic [2*div_pkg::data_width:0] rq_diff;
  logic [2*div_pkg::data_width:0] rq_next;

  assign rq_shift = rq_q << 1;
  assign rq_diff  = rq_shift - dvs_q;

  // negative trial: restore shifted value, quotient bit 0
  // otherwise keep the difference, quotient bit 1
  assign rq_next = rq_diff[2*div_pkg::data_width] ?
                   {rq_shift[2*div_pkg::data_width:1], 1'b0} :
                   {rq_diff[2*div_pkg::data_width:1], 1'b1};

  always_ff @(posedge clk) begin
    if (accept) begin
      a_neg_q  <= in_a_neg;
      b_neg_q  <= in_b_neg;
      b_zero_q <= (req_msg.b == '0);
      rq_q     <= {{(div_pkg::data_width+1){1'b0}}, in_a_mag};
      dvs_q    <= {1'b0, in_b_mag, {div_pkg::data_width{1'b0}}};
    end else if (state == div_pkg::st_calc) begin
      rq_q <= rq_next;
    end
  end

  // --------------------------------------------------------------------------
  // sign fix
  // --------------------------------------------------------------------------

  logic [div_pkg::data_width-1:0] rem_mag;
  logic [div_pkg::data_width-1:0] quot_mag;
  div_pkg::div_resp_t fixed;
  div_pkg::div_resp_t resp_q;

  assign rem_mag  = rq_q[2*div_pkg::data_width-1:div_pkg::data_width];
  assign quot_mag = rq_q[div_pkg::data_width-1:0];

  // divide by zero keeps the all-ones quotient
  // remainder follows the dividend, so x/0 gives back x
  assign fixed.quotient  = ((a_neg_q ^ b_neg_q) && !b_zero_q) ? -quot_mag : quot_mag;
  assign fixed.remainder = a_neg_q ? -rem_mag : rem_mag;

  always_ff @(posedge clk) begin
    if (state == div_pkg::st_fix) begin
      resp_q <= fixed;
    end
  end

  assign resp_msg = resp_q;

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // a held response must not change under back-pressure
  a_resp_stable: assert property (
    @(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_msg)
  );

  // the iteration counter stays within 32 steps
  a_iter_bound: assert property (
    @(posedge clk) disable iff (reset)
    (state == div_pkg::st_calc) |-> (iter_cnt < div_pkg::lane_iters)
  );

endmodule

`default_nettype wire

//--- hdl/div_collect.sv
// divide response collector
// drains lanes in round-robin order into a one-entry output register
`default_nettype none
`timescale 1ns/1ns

module div_collect (
  input  logic                                clk,
  input  logic                                reset,

  // per-lane responses
  input  logic [div_pkg::num_lanes-1:0]       lane_resp_val,
  input  div_pkg::div_resp_t                  lane_resp_msg [div_pkg::num_lanes],
  output logic [div_pkg::num_lanes-1:0]       lane_resp_rdy,

  // downstream response
  output logic                                resp_val,
  output div_pkg::div_resp_t                  resp_msg,
  input  logic                                resp_rdy
);

  // --------------------------------------------------------------------------
  // state
  // --------------------------------------------------------------------------

  // lane to drain next, same order the dispatcher filled them
  logic [div_pkg::lane_idx_width-1:0] ptr;

  // output register and its full flag
  logic                full_q;
  div_pkg::div_resp_t  out_q;

  // register can take a new entry this edge
  logic room;
  logic load;

  // free now, or being emptied on this same edge
  assign room = !full_q || resp_rdy;
  assign load = lane_resp_val[ptr] && room;

  // only the pointed lane may see rdy
  always_comb begin
    lane_resp_rdy      = '0;
    lane_resp_rdy[ptr] = room;
  end

  // --------------------------------------------------------------------------
  // pointer and full flag
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr    <= '0;
      full_q <= 1'b0;
    end else begin
      if (load) begin
        ptr    <= ptr + div_pkg::lane_idx_width'(1);
        full_q <= 1'b1;
      end else if (resp_rdy) begin
        full_q <= 1'b0;
      end
    end
  end

  // payload only, follows the full flag
  always_ff @(posedge clk) begin
    if (load) begin
      out_q <= lane_resp_msg[ptr];
    end
  end

  assign resp_val = full_q;
  assign resp_msg = out_q;

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // once offered, a response stays put until it is taken
  a_out_held: assert property (
    @(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_msg)
  );

endmodule

`default_nettype wire

//--- hdl/div_array.sv
// four-lane integer divide unit
// dispatcher, lane array and collector; responses leave in request order
`default_nettype none
`timescale 1ns/1ns

module div_array (
  input  logic                clk,
  input  logic                reset,

  input  logic                req_val,
  input  div_pkg::div_req_t   req_msg,
  output logic                req_rdy,

  output logic                resp_val,
  output div_pkg::div_resp_t  resp_msg,
  input  logic                resp_rdy
);

  // --------------------------------------------------------------------------
  // lane side wiring
  // --------------------------------------------------------------------------

  // request fan-out, one payload shared by all lanes
  logic [div_pkg::num_lanes-1:0]  lane_req_val;
  logic [div_pkg::num_lanes-1:0]  lane_req_rdy;
  div_pkg::div_req_t              lane_req_msg;

  // response fan-in
  logic [div_pkg::num_lanes-1:0]  lane_resp_val;
  logic [div_pkg::num_lanes-1:0]  lane_resp_rdy;
  div_pkg::div_resp_t             lane_resp_msg [div_pkg::num_lanes];

  div_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_msg      (req_msg),
    .req_rdy      (req_rdy),
    .lane_req_val (lane_req_val),
    .lane_req_msg (lane_req_msg),
    .lane_req_rdy (lane_req_rdy)
  );

  // identical lanes, each holds one request
  for (genvar i = 0; i < div_pkg::num_lanes; i++) begin : g_lane
    div_lane u_lane (
      .clk      (clk),
      .reset    (reset),
      .req_val  (lane_req_val[i]),
      .req_msg  (lane_req_msg),
      .req_rdy  (lane_req_rdy[i]),
      .resp_val (lane_resp_val[i]),
      .resp_msg (lane_resp_msg[i]),
      .resp_rdy (lane_resp_rdy[i])
    );
  end

  div_collect u_collect (
    .clk           (clk),
    .reset         (reset),
    .lane_resp_val (lane_resp_val),
    .lane_resp_msg (lane_resp_msg),
    .lane_resp_rdy (lane_resp_rdy),
    .resp_val      (resp_val),
    .resp_msg      (resp_msg),
    .resp_rdy      (resp_rdy)
  );

endmodule

`default_nettype wire

//--- sim/div_array_tb.sv
// testbench for the four-lane divide unit
// random val/rdy traffic with corner operands, checked against a reference queue
`default_nettype none
`timescale 1ns/1ns

module div_array_tb;

  // run length and watchdog budget in cycles
  localparam int num_reqs       = 400;
  localparam int timeout_cycles = num_reqs * 40 + 1000;

  // bound on draining the lanes and the output register at the end
  localparam int drain_cycles   = (div_pkg::num_lanes + 1) * 40;

  logic                clk;
  logic                reset;
  logic                req_val;
  div_pkg::div_req_t   req_msg;
  logic                req_rdy;
  logic                resp_val;
  div_pkg::div_resp_t  resp_msg;
  logic                resp_rdy;

  // expected responses in request order
  div_pkg::div_resp_t exp_q [$];

  int n_accepted;
  int n_resp;
  int max_inflight;
  int stall_left;
  int latency;
  int drain_wait;

  // handshake and hold state from the last rising edge
  logic                last_fire;
  logic                hold_valid;
  div_pkg::div_resp_t  held_msg;

  div_array DUT (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_msg  (req_msg),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_msg (resp_msg),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // error reporting and compares
  // --------------------------------------------------------------------------

  task automatic report_error(string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_resp(string name, div_pkg::div_resp_t got, div_pkg::div_resp_t exp);
    if (got.remainder !== exp.remainder) begin
      report_error($sformatf("Mismatch %s.remainder: got %h expected %h",
                             name, got.remainder, exp.remainder));
    end
    if (got.quotient !== exp.quotient) begin
      report_error($sformatf("Mismatch %s.quotient: got %h expected %h",
                             name, got.quotient, exp.quotient));
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      report_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      report_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model and stimulus
  // --------------------------------------------------------------------------

  // native division plus the divide-by-zero and overflow conventions
  function automatic div_pkg::div_resp_t model_div(div_pkg::div_req_t req);
    div_pkg::div_resp_t r;
    logic signed [div_pkg::data_width-1:0] sa;
    logic signed [div_pkg::data_width-1:0] sb;
    logic [div_pkg::data_width-1:0] min_neg;
    sa      = req.a;
    sb      = req.b;
    min_neg = {1'b1, {(div_pkg::data_width-1){1'b0}}};
    if (req.b == '0) begin
      r.quotient  = '1;
      r.remainder = req.a;
    end else if (req.op == div_pkg::op_div && req.a == min_neg && req.b == '1) begin
      r.quotient  = min_neg;
      r.remainder = '0;
    end else if (req.op == div_pkg::op_div) begin
      // truncates toward zero, remainder follows the dividend
      r.quotient  = sa / sb;
      r.remainder = sa % sb;
    end else begin
      r.quotient  = req.a / req.b;
      r.remainder = req.a % req.b;
    end
    return r;
  endfunction

  // corner values about a quarter of the time
  function automatic logic [div_pkg::data_width-1:0] random_operand();
    logic [div_pkg::data_width-1:0] v;
    v = $urandom;
    if ($urandom % 4 == 0) begin
      case ($urandom % 4)
        0: v = '0;
        1: v = 1;
        2: v = '1;
        default: v = {1'b1, {(div_pkg::data_width-1){1'b0}}};
      endcase
    end
    return v;
  endfunction

  function automatic div_pkg::div_req_t random_req();
    div_pkg::div_req_t r;
    r.op = ($urandom % 2 == 0) ? div_pkg::op_divu : div_pkg::op_div;
    r.a  = random_operand();
    r.b  = random_operand();
    return r;
  endfunction

  // one falling-edge update of all inputs
  task automatic drive_inputs();
    // an offered request stays put until it is taken
    if (!(req_val && !last_fire)) begin
      req_val = ($urandom % 4) != 0;
      req_msg = random_req();
    end
    // occasional long stalls on the response side
    if (stall_left > 0) begin
      stall_left--;
      resp_rdy = 1'b0;
    end else if ($urandom % 128 == 0) begin
      stall_left = 30 + int'($urandom % 50);
      resp_rdy   = 1'b0;
    end else begin
      resp_rdy = ($urandom % 3) != 0;
    end
  endtask

  // --------------------------------------------------------------------------
  // monitor, samples pre-edge values at each rising edge
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      last_fire  = 1'b0;
      hold_valid = 1'b0;
    end else begin
      last_fire = req_val && req_rdy;
      if (last_fire) begin
        exp_q.push_back(model_div(req_msg));
        n_accepted++;
      end
      // a stalled response must still be there, unchanged
      if (hold_valid) begin
        check_flag("resp_val", resp_val, 1'b1);
        check_resp("resp_msg held", resp_msg, held_msg);
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          report_error("a response arrived with no request outstanding");
        end else begin
          check_resp("resp_msg", resp_msg, exp_q.pop_front());
          n_resp++;
        end
      end
      if (exp_q.size() > max_inflight) begin
        max_inflight = exp_q.size();
      end
      hold_valid = resp_val && !resp_rdy;
      held_msg   = resp_msg;
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    report_error($sformatf("timeout, the run did not finish in %0d cycles", timeout_cycles));
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    void'($urandom(51));
    reset        = 1'b1;
    req_val      = 1'b0;
    req_msg      = '0;
    resp_rdy     = 1'b0;
    n_accepted   = 0;
    n_resp       = 0;
    max_inflight = 0;
    stall_left   = 0;
    drain_wait   = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_flag("req_rdy", req_rdy, 1'b1);
    check_flag("resp_val", resp_val, 1'b0);

    // single signed request into an idle unit, -123 / 7
    req_msg.op = div_pkg::op_div;
    req_msg.a  = 32'hffff_ff85;
    req_msg.b  = 32'h0000_0007;
    req_val    = 1'b1;
    resp_rdy   = 1'b1;
    @(negedge clk);
    req_val = 1'b0;
    latency = 0;
    while (!resp_val) begin
      @(negedge clk);
      latency++;
    end
    check_count("latency", latency, 34);

    // random traffic until the full count is accepted
    while (n_accepted < num_reqs) begin
      drive_inputs();
      @(negedge clk);
    end

    // drain whatever is still in flight, a lost response shows up as a short count
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    while (n_resp < n_accepted && drain_wait < drain_cycles) begin
      @(negedge clk);
      drain_wait++;
    end
    check_count("responses", n_resp, n_accepted);
    // four lanes plus the output register were all occupied at some point
    check_count("max in flight", max_inflight, div_pkg::num_lanes + 1);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hdl/div_pkg.sv
hdl/div_dispatch.sv
hdl/div_lane.sv
hdl/div_collect.sv
hdl/div_array.sv
sim/div_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the divide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module div_array_tb \
  -f project.f -o div_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/div_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
